//--- src.f
irq_pkg.sv
irq_prio_arbiter.sv
irq_int_controller.sv
irq_trap_seq.sv
irq_csr.sv
irq_subsys_top.sv
tb_irq_subsys.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_irq_subsys
FILELIST   := src.f
OBJ_DIR    := obj_dir
COMMON     := --timing --timescale 1ns/1ps --top-module $(TOP) -f $(FILELIST)
LINT_FLAGS := --lint-only
SIM_FLAGS  := --binary --assert -j 0 --Mdir $(OBJ_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(COMMON)

sim:
	$(VERILATOR) $(SIM_FLAGS) $(COMMON)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- tb_irq_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_irq_subsys import irq_pkg::*; ();

  logic                  clk_i;
  logic                  rst_ni;
  logic [NUM_IRQ-1:0]    irq_lines_i;
  logic                  stall_i;
  logic [XLEN-1:0]       pc_i;
  logic                  mret_i;
  logic                  csr_we_i;
  logic [CSR_ADDR_W-1:0] csr_addr_i;
  logic [XLEN-1:0]       csr_wdata_i;
  logic [XLEN-1:0]       csr_rdata_o;
  logic                  trap_o;

  // Reference model of the machine interrupt state
  logic                  exp_mie;
  logic                  exp_mpie;
  logic [XLEN-1:0]       exp_cause;
  logic [XLEN-1:0]       exp_mepc;

  logic [31:0]           lfsr_q;
  int                    trap_count = 0;

  irq_subsys_top #(
    .NUM_IRQ (NUM_IRQ)
  ) dut (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .irq_lines_i (irq_lines_i),
    .stall_i     (stall_i),
    .pc_i        (pc_i),
    .mret_i      (mret_i),
    .csr_we_i    (csr_we_i),
    .csr_addr_i  (csr_addr_i),
    .csr_wdata_i (csr_wdata_i),
    .csr_rdata_o (csr_rdata_o),
    .trap_o      (trap_o)
  );

  initial clk_i = 1'b0;
  always #5 clk_i = ~clk_i;

  // Cycles with trap_o high
  always @(posedge clk_i) begin
    if (rst_ni && trap_o) begin
      trap_count <= trap_count + 1;
    end
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  task automatic fail_stop(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp)
      else fail_stop($sformatf("FAILED %s: got 0x%h expected 0x%h", name, got, exp));
  endtask

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] draw_bits(input int n);
    logic        fb;
    logic [31:0] val;
    val = '0;
    for (int k = 0; k < n; k++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      val    = {val[30:0], fb};
    end
    return val;
  endfunction

  // Line 0 has the highest priority
  function automatic int lowest_set(input logic [31:0] w);
    int idx;
    idx = 0;
    while (idx < 31 && !w[idx]) begin
      idx++;
    end
    return idx;
  endfunction

  function automatic logic [31:0] status_word(input logic mie, input logic mpie);
    logic [31:0] w;
    w = '0;
    w[MSTATUS_MIE_BIT]  = mie;
    w[MSTATUS_MPIE_BIT] = mpie;
    return w;
  endfunction

  // Inputs change 1 ns after the edge
  task automatic step();
    @(posedge clk_i);
    #1;
  endtask

  task automatic csr_write(input logic [CSR_ADDR_W-1:0] addr, input logic [31:0] data);
    csr_we_i    = 1'b1;
    csr_addr_i  = addr;
    csr_wdata_i = data;
    step();
    csr_we_i    = 1'b0;
    if (addr == CSR_MSTATUS) begin
      exp_mie  = data[MSTATUS_MIE_BIT];
      exp_mpie = data[MSTATUS_MPIE_BIT];
    end
  endtask

  // Read port is combinational
  task automatic csr_read_expect(input logic [CSR_ADDR_W-1:0] addr,
                                 input logic [31:0] exp, input string name);
    csr_addr_i = addr;
    #1;
    check_value(name, csr_rdata_o, exp);
  endtask

  task automatic pulse_mret();
    mret_i = 1'b1;
    step();
    mret_i   = 1'b0;
    exp_mie  = exp_mpie;
    exp_mpie = 1'b1;
  endtask

  // Returns one cycle after the pulse so the counter has seen it
  task automatic wait_trap(input int limit, input int exp_id);
    int cycles;
    cycles = 0;
    while (!trap_o) begin
      step();
      cycles++;
      if (cycles > limit) begin
        fail_stop("Timed out waiting for a trap pulse");
      end
    end
    exp_mpie  = exp_mie;
    exp_mie   = 1'b0;
    exp_cause = 32'h8000_0000 | 32'(exp_id);
    exp_mepc  = pc_i;
    step();
  endtask

  task automatic expect_no_trap(input int cycles);
    int start;
    start = trap_count;
    repeat (cycles) step();
    check_value("trap_o pulse count", 32'(trap_count), 32'(start));
  endtask

  ////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////

  // A trap may only start while interrupts were enabled
  assert property (@(posedge clk_i) disable iff (!rst_ni) $rose(trap_o) |-> $past(exp_mie))
    else fail_stop("FAILED trap_o: 0x1 while expected global enable was 0x0");

  assert property (@(posedge clk_i) disable iff (!rst_ni) !(trap_o && $past(trap_o)))
    else fail_stop("FAILED trap_o: 0x1 for a second cycle, expected 0x0");

  initial begin
    #100us;
    fail_stop("Watchdog expired before the test finished");
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial begin
    logic [31:0] pattern;
    logic [31:0] saved_mepc;
    logic [31:0] saved_cause;
    int          count_before;
    int          line;
    rst_ni      = 1'b0;
    irq_lines_i = '0;
    stall_i     = 1'b0;
    pc_i        = '0;
    mret_i      = 1'b0;
    csr_we_i    = 1'b0;
    csr_addr_i  = '0;
    csr_wdata_i = '0;
    exp_mie     = 1'b0;
    exp_mpie    = 1'b0;
    exp_cause   = '0;
    exp_mepc    = '0;
    lfsr_q      = 32'h00bd_f2dc;
    repeat (3) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    // Everything reads zero out of reset
    csr_read_expect(CSR_MSTATUS, 32'h0, "mstatus");
    csr_read_expect(CSR_MIE, 32'h0, "mie");
    csr_read_expect(CSR_MEPC, 32'h0, "mepc");
    csr_read_expect(CSR_MCAUSE, 32'h0, "mcause");
    csr_read_expect(12'h7c0, 32'h0, "unmapped csr");

    // Priority with random line patterns
    csr_write(CSR_MIE, 32'hffff_ffff);
    csr_write(CSR_MSTATUS, status_word(1'b1, 1'b0));
    for (int r = 0; r < 4; r++) begin
      pc_i = 32'h8000_0100 + 32'(r) * 32'h40;
      pattern = draw_bits(32);
      if (pattern == '0) begin
        pattern = 32'h1;
      end
      count_before = trap_count;
      irq_lines_i  = pattern;
      wait_trap(20, lowest_set(pattern));
      irq_lines_i = '0;
      check_value("trap_o pulse count", 32'(trap_count), 32'(count_before + 1));
      expect_no_trap(6);
      csr_read_expect(CSR_MCAUSE, exp_cause, "mcause");
      csr_read_expect(CSR_MEPC, exp_mepc, "mepc");
      csr_read_expect(CSR_MSTATUS, status_word(exp_mie, exp_mpie), "mstatus");
      pulse_mret();
      csr_read_expect(CSR_MSTATUS, status_word(exp_mie, exp_mpie), "mstatus");
    end

    // Masked lines stay silent until enabled
    csr_write(CSR_MIE, 32'hffff_0000);
    pattern = draw_bits(16);
    if (pattern == '0) begin
      pattern = 32'h0000_0100;
    end
    irq_lines_i = pattern;
    expect_no_trap(20);
    line = lowest_set(pattern);
    pc_i = 32'h8000_0400;
    csr_write(CSR_MIE, 32'hffff_0000 | (32'd1 << line));
    wait_trap(20, line);
    irq_lines_i = '0;
    expect_no_trap(4);
    csr_read_expect(CSR_MCAUSE, exp_cause, "mcause");
    csr_read_expect(CSR_MEPC, exp_mepc, "mepc");
    pulse_mret();

    // Back-pressure holds the request
    csr_write(CSR_MIE, 32'hffff_ffff);
    pc_i    = 32'h8000_0800;
    stall_i = 1'b1;
    pattern = draw_bits(32);
    if (pattern == '0) begin
      pattern = 32'h8000_0000;
    end
    irq_lines_i = pattern;
    expect_no_trap(15);
    stall_i = 1'b0;
    wait_trap(20, lowest_set(pattern));
    irq_lines_i = '0;
    expect_no_trap(4);
    csr_read_expect(CSR_MCAUSE, exp_cause, "mcause");
    csr_read_expect(CSR_MEPC, exp_mepc, "mepc");
    pulse_mret();

    // Kill a stalled request by clearing the global enable
    saved_mepc  = exp_mepc;
    saved_cause = exp_cause;
    pc_i        = 32'h9000_0f00;
    stall_i     = 1'b1;
    irq_lines_i = 32'h0000_0020;
    repeat (3) step();
    csr_write(CSR_MSTATUS, 32'h0);
    stall_i     = 1'b0;
    irq_lines_i = '0;
    expect_no_trap(12);
    csr_read_expect(CSR_MSTATUS, status_word(exp_mie, exp_mpie), "mstatus");

    // Killed request is gone, so enabling again takes nothing
    csr_write(CSR_MSTATUS, status_word(1'b1, 1'b0));
    expect_no_trap(8);
    csr_read_expect(CSR_MEPC, saved_mepc, "mepc");
    csr_read_expect(CSR_MCAUSE, saved_cause, "mcause");

    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- irq_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

module irq_subsys_top import irq_pkg::*; #(
  parameter int unsigned NUM_IRQ = irq_pkg::NUM_IRQ
) (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,

  // Level interrupt lines
  input  wire logic [NUM_IRQ-1:0]    irq_lines_i,

  // Stand-ins for the pipeline
  input  wire logic                  stall_i,
  input  wire logic [XLEN-1:0]       pc_i,
  input  wire logic                  mret_i,

  // Software CSR port
  input  wire logic                  csr_we_i,
  input  wire logic [CSR_ADDR_W-1:0] csr_addr_i,
  input  wire logic [XLEN-1:0]       csr_wdata_i,
  output logic [XLEN-1:0]            csr_rdata_o,

  output logic                       trap_o
);

  ////////////////////////////////////////
  // Internal nets
  ////////////////////////////////////////

  // Arbiter to controller
  logic                irq;
  logic [IRQ_ID_W-1:0] irq_id;

  // Controller and sequencer exchange
  logic                irq_req_ctrl;
  logic [IRQ_ID_W-1:0] irq_id_ctrl;
  logic                ctrl_ack;
  logic                ctrl_kill;

  // Sequencer to CSRs
  logic                trap_take;
  logic [IRQ_ID_W-1:0] trap_id;

  // CSR enables
  logic                m_ie;
  logic [NUM_IRQ-1:0]  irq_mask;

  ////////////////////////////////////////
  // Instances
  ////////////////////////////////////////

  // Lowest enabled line wins
  irq_prio_arbiter #(
    .NUM_IRQ (NUM_IRQ)
  ) u_arbiter (
    .irq_lines_i (irq_lines_i),
    .irq_mask_i  (irq_mask),
    .irq_o       (irq),
    .irq_id_o    (irq_id)
  );

  irq_int_controller u_int_controller (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .irq_i          (irq),
    .irq_id_i       (irq_id),
    .m_ie_i         (m_ie),
    .ctrl_ack_i     (ctrl_ack),
    .ctrl_kill_i    (ctrl_kill),
    .irq_req_ctrl_o (irq_req_ctrl),
    .irq_id_ctrl_o  (irq_id_ctrl)
  );

  // Core controller model
  irq_trap_seq u_trap_seq (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .irq_req_i   (irq_req_ctrl),
    .irq_id_i    (irq_id_ctrl),
    .stall_i     (stall_i),
    .m_ie_i      (m_ie),
    .ctrl_ack_o  (ctrl_ack),
    .ctrl_kill_o (ctrl_kill),
    .trap_take_o (trap_take),
    .trap_id_o   (trap_id),
    .trap_o      (trap_o)
  );

  irq_csr #(
    .NUM_IRQ (NUM_IRQ)
  ) u_csr (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .csr_we_i    (csr_we_i),
    .csr_addr_i  (csr_addr_i),
    .csr_wdata_i (csr_wdata_i),
    .csr_rdata_o (csr_rdata_o),
    .trap_take_i (trap_take),
    .trap_id_i   (trap_id),
    .pc_i        (pc_i),
    .mret_i      (mret_i),
    .m_ie_o      (m_ie),
    .irq_mask_o  (irq_mask)
  );

endmodule

`default_nettype wire

//--- irq_csr.sv
`timescale 1ns/1ps
`default_nettype none

module irq_csr import irq_pkg::*; #(
  parameter int unsigned NUM_IRQ = irq_pkg::NUM_IRQ
) (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,

  // Software access port
  input  wire logic                  csr_we_i,
  input  wire logic [CSR_ADDR_W-1:0] csr_addr_i,
  input  wire logic [XLEN-1:0]       csr_wdata_i,
  output logic [XLEN-1:0]            csr_rdata_o,

  // Trap entry and return from the sequencer
  input  wire logic                  trap_take_i,
  input  wire logic [IRQ_ID_W-1:0]   trap_id_i,
  input  wire logic [XLEN-1:0]       pc_i,
  input  wire logic                  mret_i,

  // Enables back into the interrupt path
  output logic                       m_ie_o,
  output logic [NUM_IRQ-1:0]         irq_mask_o
);

  ////////////////////////////////////////
  // Registers
  ////////////////////////////////////////

  // mstatus fields
  logic               mie_q;
  logic               mie_d;
  logic               mpie_q;
  logic               mpie_d;

  // mie as a per-line mask
  logic [NUM_IRQ-1:0] mask_q;
  logic [NUM_IRQ-1:0] mask_d;

  logic [XLEN-1:0]    mepc_q;
  logic [XLEN-1:0]    mepc_d;
  mcause_u            mcause_q;
  mcause_u            mcause_d;

  // Software write decode
  logic               wr_mstatus;
  logic               wr_mie;
  logic               wr_mepc;
  logic               wr_mcause;

  assign wr_mstatus = csr_we_i && (csr_addr_i == CSR_MSTATUS);
  assign wr_mie     = csr_we_i && (csr_addr_i == CSR_MIE);
  assign wr_mepc    = csr_we_i && (csr_addr_i == CSR_MEPC);
  assign wr_mcause  = csr_we_i && (csr_addr_i == CSR_MCAUSE);

  ////////////////////////////////////////
  // Update priority
  ////////////////////////////////////////

  // Trap first, then mret, then software
  always_comb begin
    mie_d    = mie_q;
    mpie_d   = mpie_q;
    mask_d   = mask_q;
    mepc_d   = mepc_q;
    mcause_d = mcause_q;

    if (trap_take_i) begin
      // Save the enable and shut interrupts off
      mpie_d = mie_q;
      mie_d  = 1'b0;
    end else if (mret_i) begin
      mie_d  = mpie_q;
      mpie_d = 1'b1;
    end else if (wr_mstatus) begin
      mie_d  = csr_wdata_i[MSTATUS_MIE_BIT];
      mpie_d = csr_wdata_i[MSTATUS_MPIE_BIT];
    end

    // Mask has no hardware writer
    if (wr_mie) begin
      mask_d = csr_wdata_i[NUM_IRQ-1:0];
    end

    if (trap_take_i) begin
      mepc_d                = pc_i;
      mcause_d.fields.irq   = 1'b1;
      mcause_d.fields.rsvd  = '0;
      mcause_d.fields.code  = trap_id_i;
    end else begin
      if (wr_mepc) begin
        mepc_d = csr_wdata_i;
      end
      if (wr_mcause) begin
        mcause_d.raw = csr_wdata_i;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mie_q        <= 1'b0;
      mpie_q       <= 1'b0;
      mask_q       <= '0;
      mepc_q       <= '0;
      mcause_q.raw <= '0;
    end else begin
      mie_q    <= mie_d;
      mpie_q   <= mpie_d;
      mask_q   <= mask_d;
      mepc_q   <= mepc_d;
      mcause_q <= mcause_d;
    end
  end

  assign m_ie_o     = mie_q;
  assign irq_mask_o = mask_q;

  ////////////////////////////////////////
  // Read mux
  ////////////////////////////////////////

  // Unmapped addresses read as zero
  always_comb begin
    csr_rdata_o = '0;
    unique case (csr_addr_i)
      CSR_MSTATUS: begin
        csr_rdata_o[MSTATUS_MIE_BIT]  = mie_q;
        csr_rdata_o[MSTATUS_MPIE_BIT] = mpie_q;
      end
      CSR_MIE:    csr_rdata_o[NUM_IRQ-1:0] = mask_q;
      CSR_MEPC:   csr_rdata_o = mepc_q;
      CSR_MCAUSE: csr_rdata_o = mcause_q.raw;
      default:    csr_rdata_o = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- irq_trap_seq.sv
`timescale 1ns/1ps
`default_nettype none

module irq_trap_seq import irq_pkg::*; (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,

  // Request from the interrupt controller
  input  wire logic                irq_req_i,
  input  wire logic [IRQ_ID_W-1:0] irq_id_i,

  // Pipeline and enable state
  input  wire logic                stall_i,
  input  wire logic                m_ie_i,

  // Answer to the interrupt controller
  output logic                     ctrl_ack_o,
  output logic                     ctrl_kill_o,

  // Trap entry towards the CSRs
  output logic                     trap_take_o,
  output logic [IRQ_ID_W-1:0]      trap_id_o,
  output logic                     trap_o
);

  ////////////////////////////////////////
  // Accept or withdraw
  ////////////////////////////////////////

  // Registered copy of the taken trap
  logic trap_q;

  // Take the request once the pipeline is free
  // Enable must still be set at that point
  assign ctrl_ack_o = irq_req_i && !stall_i && m_ie_i;

  // Enable dropped while waiting so drop the request
  // Independent of stall so a stalled request can still be killed
  assign ctrl_kill_o = irq_req_i && !m_ie_i;

  ////////////////////////////////////////
  // Trap entry
  ////////////////////////////////////////

  // CSR update happens on the acknowledge edge
  assign trap_take_o = ctrl_ack_o;
  assign trap_id_o   = irq_id_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      trap_q <= 1'b0;
    end else begin
      trap_q <= ctrl_ack_o;
    end
  end

  // High for the cycle after the acknowledge
  assign trap_o = trap_q;

endmodule

`default_nettype wire

//--- irq_int_controller.sv
`timescale 1ns/1ps
`default_nettype none

module irq_int_controller import irq_pkg::*; (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,

  // From the arbiter
  input  wire logic                irq_i,
  input  wire logic [IRQ_ID_W-1:0] irq_id_i,

  // Global enable from mstatus
  input  wire logic                m_ie_i,

  // Response from the core side
  input  wire logic                ctrl_ack_i,
  input  wire logic                ctrl_kill_i,

  // Request towards the core side
  output logic                     irq_req_ctrl_o,
  output logic [IRQ_ID_W-1:0]      irq_id_ctrl_o
);

  ////////////////////////////////////////
  // State
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_PENDING,
    ST_DONE
  } irq_state_e;

  irq_state_e          state_q;
  irq_state_e          state_d;

  // Id captured on entry to pending
  logic [IRQ_ID_W-1:0] irq_id_q;
  logic [IRQ_ID_W-1:0] irq_id_d;

  // Request is a pure decode of the state
  assign irq_req_ctrl_o = (state_q == ST_PENDING);
  assign irq_id_ctrl_o  = irq_id_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= ST_IDLE;
      irq_id_q <= '0;
    end else begin
      state_q  <= state_d;
      irq_id_q <= irq_id_d;
    end
  end

  ////////////////////////////////////////
  // Next state
  ////////////////////////////////////////

  always_comb begin
    state_d  = state_q;
    irq_id_d = irq_id_q;
    unique case (state_q)
      // Only qualify lines while globally enabled
      ST_IDLE: begin
        if (m_ie_i && irq_i) begin
          state_d  = ST_PENDING;
          irq_id_d = irq_id_i;
        end
      end
      // Hold id stable until the core answers
      ST_PENDING: begin
        if (ctrl_ack_i) begin
          state_d = ST_DONE;
        end else if (ctrl_kill_i) begin
          state_d = ST_IDLE;
        end
      end
      // One dead cycle after a taken trap
      ST_DONE: begin
        state_d = ST_IDLE;
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- irq_prio_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module irq_prio_arbiter import irq_pkg::*; #(
  parameter int unsigned NUM_IRQ = irq_pkg::NUM_IRQ
) (
  input  wire logic [NUM_IRQ-1:0]  irq_lines_i,
  input  wire logic [NUM_IRQ-1:0]  irq_mask_i,
  output logic                     irq_o,
  output logic [IRQ_ID_W-1:0]      irq_id_o
);

  ////////////////////////////////////////
  // Masking
  ////////////////////////////////////////

  // Lines allowed to interrupt this cycle
  logic [NUM_IRQ-1:0] irq_masked;

  assign irq_masked = irq_lines_i & irq_mask_i;

  // Any enabled line still high
  assign irq_o = |irq_masked;

  ////////////////////////////////////////
  // Fixed priority encode
  ////////////////////////////////////////

  // Line 0 is the highest priority
  // Walk down from the top so the lowest set index is written last
  always_comb begin
    irq_id_o = '0;
    for (int i = NUM_IRQ - 1; i >= 0; i--) begin
      if (irq_masked[i]) begin
        irq_id_o = IRQ_ID_W'(i);
      end
    end
  end

  // Id is only meaningful while irq_o is high
  // With no line pending the encoder falls back to zero

endmodule

`default_nettype wire

//--- irq_pkg.sv
`default_nettype none

package irq_pkg;

  ////////////////////////////////////////
  // Sizing
  ////////////////////////////////////////

  // Data path width of the core
  localparam int unsigned XLEN = 32;

  // Default count of level interrupt lines
  localparam int unsigned NUM_IRQ = 32;

  // Id wide enough to name every line
  localparam int unsigned IRQ_ID_W = $clog2(NUM_IRQ);

  ////////////////////////////////////////
  // CSR map (machine mode only)
  ////////////////////////////////////////

  localparam int unsigned CSR_ADDR_W = 12;

  localparam logic [CSR_ADDR_W-1:0] CSR_MSTATUS = 12'h300;
  localparam logic [CSR_ADDR_W-1:0] CSR_MIE     = 12'h304;
  localparam logic [CSR_ADDR_W-1:0] CSR_MEPC    = 12'h341;
  localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE  = 12'h342;

  // Global enable and its saved copy inside mstatus
  localparam int unsigned MSTATUS_MIE_BIT  = 3;
  localparam int unsigned MSTATUS_MPIE_BIT = 7;

  ////////////////////////////////////////
  // Cause word
  ////////////////////////////////////////

  // Interrupt flag on top, code in the low bits
  typedef struct packed {
    logic                     irq;
    logic [XLEN-2-IRQ_ID_W:0] rsvd;
    logic [IRQ_ID_W-1:0]      code;
  } mcause_fields_t;

  // Software sees raw, trap logic fills fields
  typedef union packed {
    logic [XLEN-1:0] raw;
    mcause_fields_t  fields;
  } mcause_u;

endpackage

`default_nettype wire
